//--- rn_rename.f
rn_pkg.sv
rn_decode.sv
rn_rat.sv
rn_free_list.sv
rn_dispatch.sv
rn_rename_top.sv
tb_rn_rename.sv

//--- Bender.yml
package:
  name: rn_rename

sources:
  - rn_pkg.sv
  - rn_decode.sv
  - rn_rat.sv
  - rn_free_list.sv
  - rn_dispatch.sv
  - rn_rename_top.sv
  - target: test
    files:
      - tb_rn_rename.sv

//--- tb_rn_rename.sv
//******************************
// Rename stage testbench
// Front-end, scheduler and ROB models with
// a reference rename model and output checks
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_rn_rename;

   typedef rn_pkg::rn_out_t [rn_pkg::ISSUE_W-1:0] grp_out_t;

   logic                                  clk;
   logic                                  arst_n;
   rn_pkg::insn_t   [rn_pkg::ISSUE_W-1:0] grp_insn;
   logic            [rn_pkg::ISSUE_W-1:0] grp_valid;
   logic                                  grp_ready;
   logic                                  rollback;
   rn_pkg::rn_cmt_t [rn_pkg::ISSUE_W-1:0] cmt;
   grp_out_t                              out_grp;
   logic                                  out_valid;
   logic                                  sch_credit;

   // Reference state
   rn_pkg::preg_t   m_spec [rn_pkg::N_LREG];
   rn_pkg::preg_t   m_arch [rn_pkg::N_LREG];
   rn_pkg::preg_t   m_fl   [rn_pkg::N_FREE];
   int              m_spec_head;
   int              m_cmt_head;
   int              m_tail;
   int              credits;
   int              sched_held;
   rn_pkg::rn_cmt_t rob_q [$];
   grp_out_t        exp_q [$];

   // Front end and phase controls
   rn_pkg::insn_t   [1:0] cur_insn;
   logic            [1:0] cur_valid;
   logic            consumed;
   logic            quiesce;
   logic            commit_en;
   logic            credit_hold;
   int              opc_mode;
   int              rb_rate;
   int              stall_cnt;
   logic            credit_stall_seen;
   logic            fl_stall_seen;
   logic [31:0]     seed;
   int              errors;

   rn_rename_top dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .grp_insn   (grp_insn),
      .grp_valid  (grp_valid),
      .grp_ready  (grp_ready),
      .rollback   (rollback),
      .cmt        (cmt),
      .out_grp    (out_grp),
      .out_valid  (out_valid),
      .sch_credit (sch_credit)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed >> 8;
   endfunction

   // {rs1 read, rs2 read, rd write} of a major opcode
   function automatic logic [2:0] opc_flags(input logic [6:0] opc);
      case (opc)
         rn_pkg::OPC_OP:     return 3'b111;
         rn_pkg::OPC_OP_IMM: return 3'b101;
         rn_pkg::OPC_LOAD:   return 3'b101;
         rn_pkg::OPC_STORE:  return 3'b110;
         rn_pkg::OPC_BRANCH: return 3'b110;
         rn_pkg::OPC_LUI:    return 3'b001;
         default:            return 3'b000;
      endcase
   endfunction

   function automatic rn_pkg::insn_t make_insn(input logic [6:0] opc, input int rd,
                                               input int rs1, input int rs2);
      return {7'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), opc};
   endfunction

   function automatic rn_pkg::insn_t rand_insn();
      logic [6:0] opc;
      int         pick;
      int         rd;
      pick = next_rand() % 7;
      if (opc_mode == 1)
      begin
         pick = next_rand() % 4;
      end
      case (pick)
         0:       opc = rn_pkg::OPC_OP;
         1:       opc = rn_pkg::OPC_OP_IMM;
         2:       opc = rn_pkg::OPC_LOAD;
         3:       opc = rn_pkg::OPC_LUI;
         4:       opc = rn_pkg::OPC_STORE;
         5:       opc = rn_pkg::OPC_BRANCH;
         default: opc = 7'b1111111;
      endcase
      // Small register range most of the time to provoke hazards
      rd = (next_rand() % 4 == 0) ? next_rand() % 32 : next_rand() % 8;
      if (opc_mode == 1 && rd == 0)
      begin
         rd = 1;
      end
      return make_insn(opc, rd, next_rand() % 8, next_rand() % 8);
   endfunction

   function automatic int count_writes(input rn_pkg::insn_t [1:0] insn,
                                       input logic [1:0] vld);
      int         n;
      logic [2:0] f;
      n = 0;
      for (int i = 0; i < 2; i++)
      begin
         f = opc_flags(insn[i][6:0]);
         if (vld[i] && f[0] && insn[i][11:7] != 0)
         begin
            n++;
         end
      end
      return n;
   endfunction

   // Renames one accepted group against the model and queues ROB entries
   function automatic grp_out_t rename_ref(input rn_pkg::insn_t [1:0] insn,
                                           input logic [1:0] vld);
      grp_out_t        r;
      rn_pkg::lreg_t   lrd [2];
      rn_pkg::lreg_t   rs1;
      rn_pkg::lreg_t   rs2;
      rn_pkg::preg_t   p1;
      rn_pkg::preg_t   p2;
      rn_pkg::preg_t   pf;
      rn_pkg::rn_cmt_t e;
      logic [2:0]      f;
      logic            we;
      int              k;
      k = 0;
      for (int i = 0; i < 2; i++)
      begin
         f      = opc_flags(insn[i][6:0]);
         rs1    = insn[i][19:15];
         rs2    = insn[i][24:20];
         lrd[i] = insn[i][11:7];
         we     = vld[i] & f[0] & (lrd[i] != 0);
         p1     = m_spec[rs1];
         p2     = m_spec[rs2];
         pf     = m_spec[lrd[i]];
         if (i == 1 && r[0].lrd_we)
         begin
            if (rs1 == lrd[0])
            begin
               p1 = r[0].prd;
            end
            if (rs2 == lrd[0])
            begin
               p2 = r[0].prd;
            end
            if (we && lrd[1] == lrd[0])
            begin
               pf = r[0].prd;
            end
         end
         r[i].rs1_use = vld[i] & f[2];
         r[i].rs2_use = vld[i] & f[1];
         r[i].lrd_we  = we;
         r[i].valid   = vld[i];
         r[i].prs1    = r[i].rs1_use ? p1 : '0;
         r[i].prs2    = r[i].rs2_use ? p2 : '0;
         r[i].prd     = we ? m_fl[(m_spec_head + k) % rn_pkg::N_FREE] : '0;
         r[i].pfree   = we ? pf : '0;
         if (we)
         begin
            k++;
         end
      end
      for (int i = 0; i < 2; i++)
      begin
         if (r[i].lrd_we)
         begin
            m_spec[lrd[i]] = r[i].prd;
            e = '{fire: 1'b1, prd_we: 1'b1, lrd: lrd[i], prd: r[i].prd, pfree: r[i].pfree};
            rob_q.push_back(e);
         end
      end
      m_spec_head += k;
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("Fail %s got %h expected %h", name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic report_error(input string what);
      errors++;
      $display("Error: %s", what);
      $display("RESULT: FAIL");
      $fatal(1, "run aborted");
   endtask

   // One front-end, scheduler and ROB cycle, driven on the falling edge
   task automatic step();
      logic crd;
      logic rb;
      logic exp_ready;
      int   n;
      int   need;
      @(negedge clk);
      if (consumed)
      begin
         cur_insn[0] = rand_insn();
         cur_insn[1] = rand_insn();
         cur_valid   = quiesce ? 2'b00 : 2'(next_rand() % 4);
      end
      crd = (sched_held > 0) && !credit_hold && (next_rand() % 3 == 0);
      rb  = (rb_rate != 0) && (next_rand() % rb_rate == 0);
      n   = (commit_en && !rb) ? next_rand() % 3 : 0;
      if (n > rob_q.size())
      begin
         n = rob_q.size();
      end
      cmt = '0;
      for (int i = 0; i < n; i++)
      begin
         cmt[i] = rob_q[i];
      end
      grp_insn   = cur_insn;
      grp_valid  = cur_valid;
      rollback   = rb;
      sch_credit = crd;
      #1;
      need      = count_writes(cur_insn, cur_valid);
      exp_ready = !rb && credits > 0 && (m_tail - m_spec_head) >= need;
      check("grp_ready", grp_ready, exp_ready);
      if (credits == 0 && |cur_valid)
      begin
         credit_stall_seen = 1'b1;
      end
      if ((m_tail - m_spec_head) < need && credits > 0)
      begin
         fl_stall_seen = 1'b1;
      end
      if (exp_ready && |cur_valid)
      begin
         exp_q.push_back(rename_ref(cur_insn, cur_valid));
         credits--;
         consumed  = 1'b1;
         stall_cnt = 0;
      end
      else if (|cur_valid)
      begin
         consumed = 1'b0;
         stall_cnt++;
         if (stall_cnt > 2000)
         begin
            report_error("front-end group was never accepted");
         end
      end
      else
      begin
         consumed = 1'b1;
      end
      if (crd)
      begin
         credits++;
         sched_held--;
      end
      if (rb)
      begin
         m_spec      = m_arch;
         m_spec_head = m_cmt_head;
         rob_q.delete();
      end
      for (int i = 0; i < n; i++)
      begin
         m_arch[cmt[i].lrd]            = cmt[i].prd;
         m_fl[m_tail % rn_pkg::N_FREE] = cmt[i].pfree;
         m_tail++;
         m_cmt_head++;
         void'(rob_q.pop_front());
      end
   endtask

   // Presents a fixed group and waits for its acceptance
   task automatic offer(input rn_pkg::insn_t i0, input rn_pkg::insn_t i1);
      int cnt;
      cur_insn[0] = i0;
      cur_insn[1] = i1;
      cur_valid   = 2'b11;
      consumed    = 1'b0;
      cnt         = 0;
      while (!consumed)
      begin
         step();
         cnt++;
         if (cnt > 200)
         begin
            report_error("directed group was not accepted in time");
         end
      end
   endtask

   // Scheduler side: exact one-cycle latency and field compare
   initial
   begin
      grp_out_t e;
      forever
      begin
         @(posedge clk);
         #1;
         if (arst_n && out_valid)
         begin
            if (exp_q.size() == 0)
            begin
               report_error("out_valid asserted without an accepted group");
            end
            e = exp_q.pop_front();
            for (int i = 0; i < 2; i++)
            begin
               check($sformatf("out_grp[%0d].prs1", i), out_grp[i].prs1, e[i].prs1);
               check($sformatf("out_grp[%0d].prs2", i), out_grp[i].prs2, e[i].prs2);
               check($sformatf("out_grp[%0d].prd", i), out_grp[i].prd, e[i].prd);
               check($sformatf("out_grp[%0d].pfree", i), out_grp[i].pfree, e[i].pfree);
               check($sformatf("out_grp[%0d].rs1_use", i), out_grp[i].rs1_use, e[i].rs1_use);
               check($sformatf("out_grp[%0d].rs2_use", i), out_grp[i].rs2_use, e[i].rs2_use);
               check($sformatf("out_grp[%0d].lrd_we", i), out_grp[i].lrd_we, e[i].lrd_we);
               check($sformatf("out_grp[%0d].valid", i), out_grp[i].valid, e[i].valid);
            end
            sched_held++;
         end
         else if (arst_n && exp_q.size() != 0)
         begin
            report_error("renamed group did not appear one cycle after acceptance");
         end
      end
   end

   initial
   begin
      repeat (100000) @(posedge clk);
      report_error("simulation watchdog expired");
   end

   initial
   begin
      int cnt;
      seed = 32'hda786eba;
      errors = 0;
      arst_n = 1'b0;
      grp_insn = '0;
      grp_valid = '0;
      rollback = 1'b0;
      cmt = '0;
      sch_credit = 1'b0;
      for (int i = 0; i < rn_pkg::N_LREG; i++)
      begin
         m_spec[i] = rn_pkg::preg_t'(i);
         m_arch[i] = rn_pkg::preg_t'(i);
         m_fl[i]   = rn_pkg::preg_t'(32 + i);
      end
      m_spec_head = 0;
      m_cmt_head = 0;
      m_tail = rn_pkg::N_FREE;
      credits = rn_pkg::SCH_CREDITS;
      sched_held = 0;
      consumed = 1'b1;
      quiesce = 1'b0;
      commit_en = 1'b0;
      credit_hold = 1'b0;
      opc_mode = 0;
      rb_rate = 0;
      stall_cnt = 0;
      credit_stall_seen = 1'b0;
      fl_stall_seen = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Identity mapping and first allocations
      offer(make_insn(rn_pkg::OPC_OP, 1, 2, 3), make_insn(rn_pkg::OPC_OP, 4, 1, 1));
      @(posedge clk);
      #1;
      check("out_grp[0].prs1", out_grp[0].prs1, 2);
      check("out_grp[0].prd", out_grp[0].prd, 32);
      check("out_grp[1].prs1", out_grp[1].prs1, 32);
      check("out_grp[1].prd", out_grp[1].prd, 33);

      // WAW, x0 destination, store, branch and unknown opcode
      offer(make_insn(rn_pkg::OPC_OP_IMM, 5, 5, 0), make_insn(rn_pkg::OPC_LOAD, 5, 5, 0));
      offer(make_insn(rn_pkg::OPC_STORE, 0, 5, 4), make_insn(rn_pkg::OPC_OP, 0, 1, 5));
      offer(make_insn(rn_pkg::OPC_BRANCH, 3, 5, 1), make_insn(7'b1111111, 6, 2, 3));
      offer(make_insn(rn_pkg::OPC_LUI, 7, 9, 9), make_insn(rn_pkg::OPC_OP, 8, 7, 5));

      // Scheduler withholds credits
      credit_hold = 1'b1;
      repeat (30) step();
      check("credit stall seen", credit_stall_seen, 1);
      credit_hold = 1'b0;
      repeat (30) step();

      // Free-list exhaustion, then recycling through commits
      opc_mode = 1;
      repeat (80) step();
      check("free-list stall seen", fl_stall_seen, 1);
      commit_en = 1'b1;
      repeat (200) step();

      // Speculation followed by rollbacks
      opc_mode = 0;
      rb_rate = 8;
      repeat (100) step();

      // Long mixed run
      rb_rate = 64;
      repeat (6000) step();

      // Drain scheduler and ROB
      rb_rate = 0;
      quiesce = 1'b1;
      cnt = 0;
      while (!consumed || rob_q.size() != 0 || sched_held != 0 || exp_q.size() != 0)
      begin
         step();
         cnt++;
         if (cnt > 1000)
         begin
            report_error("drain of scheduler and ROB did not complete");
         end
      end
      check("credits after drain", credits, rn_pkg::SCH_CREDITS);

      if (errors == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- rn_rename_top.sv
//******************************
// Register rename stage
// Two-wide decode, RAT lookup, free-list
// allocation and registered dispatch
//******************************
`timescale 1ns/1ps
`default_nettype none

module rn_rename_top
(
   input  logic                                   clk,
   input  logic                                   arst_n,
   input  rn_pkg::insn_t   [rn_pkg::ISSUE_W-1:0]  grp_insn,
   input  logic            [rn_pkg::ISSUE_W-1:0]  grp_valid,
   output logic                                   grp_ready,
   input  logic                                   rollback,
   input  rn_pkg::rn_cmt_t [rn_pkg::ISSUE_W-1:0]  cmt,
   output rn_pkg::rn_out_t [rn_pkg::ISSUE_W-1:0]  out_grp,
   output logic                                   out_valid,
   input  logic                                   sch_credit
);

   rn_pkg::rn_dec_t [rn_pkg::ISSUE_W-1:0] dec;
   rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0] alloc_prd;
   rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0] prs1;
   rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0] prs2;
   rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0] pfree;
   logic                                  enough;
   logic                                  has_credit;
   logic                                  fire;

   // Stall on rollback, no scheduler slot, or too few free registers
   assign grp_ready = ~rollback & has_credit & enough;
   assign fire      = grp_ready & (|grp_valid);

   rn_decode u_decode (
      .grp_insn  (grp_insn),
      .grp_valid (grp_valid),
      .dec       (dec)
   );

   rn_rat u_rat (
      .clk       (clk),
      .arst_n    (arst_n),
      .fire      (fire),
      .rollback  (rollback),
      .dec       (dec),
      .alloc_prd (alloc_prd),
      .cmt       (cmt),
      .prs1      (prs1),
      .prs2      (prs2),
      .pfree     (pfree)
   );

   rn_free_list u_free_list (
      .clk       (clk),
      .arst_n    (arst_n),
      .fire      (fire),
      .rollback  (rollback),
      .dec       (dec),
      .cmt       (cmt),
      .alloc_prd (alloc_prd),
      .enough    (enough)
   );

   rn_dispatch u_dispatch (
      .clk        (clk),
      .arst_n     (arst_n),
      .fire       (fire),
      .rollback   (rollback),
      .dec        (dec),
      .alloc_prd  (alloc_prd),
      .prs1       (prs1),
      .prs2       (prs2),
      .pfree      (pfree),
      .sch_credit (sch_credit),
      .has_credit (has_credit),
      .out_grp    (out_grp),
      .out_valid  (out_valid)
   );

endmodule

`default_nettype wire

//--- rn_dispatch.sv
//******************************
// Rename dispatch
// Output register for the renamed group and
// scheduler credit counter
//******************************
`timescale 1ns/1ps
`default_nettype none

module rn_dispatch
(
   input  logic                                   clk,
   input  logic                                   arst_n,
   input  logic                                   fire,
   input  logic                                   rollback,
   input  rn_pkg::rn_dec_t [rn_pkg::ISSUE_W-1:0]  dec,
   input  rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  alloc_prd,
   input  rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  prs1,
   input  rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  prs2,
   input  rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  pfree,
   input  logic                                   sch_credit,
   output logic                                   has_credit,
   output rn_pkg::rn_out_t [rn_pkg::ISSUE_W-1:0]  out_grp,
   output logic                                   out_valid
);

   rn_pkg::rn_out_t [rn_pkg::ISSUE_W-1:0] grp_d;
   rn_pkg::cred_t                         cred_q;

   // Fields with no meaning for the slot go out as zero
   always_comb
   begin
      for (int i = 0; i < rn_pkg::ISSUE_W; i++)
      begin
         grp_d[i].prs1    = dec[i].rs1_use ? prs1[i] : '0;
         grp_d[i].prs2    = dec[i].rs2_use ? prs2[i] : '0;
         grp_d[i].prd     = dec[i].lrd_we ? alloc_prd[i] : '0;
         grp_d[i].pfree   = dec[i].lrd_we ? pfree[i] : '0;
         grp_d[i].rs1_use = dec[i].rs1_use;
         grp_d[i].rs2_use = dec[i].rs2_use;
         grp_d[i].lrd_we  = dec[i].lrd_we;
         grp_d[i].valid   = dec[i].valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fire)
      begin
         out_grp <= grp_d;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         out_valid <= 1'b0;
         cred_q    <= rn_pkg::cred_t'(rn_pkg::SCH_CREDITS);
      end
      else
      begin
         out_valid <= fire & ~rollback;
         // A send and a return on the same edge cancel out
         case ({fire, sch_credit})
            2'b10:   cred_q <= cred_q - rn_pkg::cred_t'(1);
            2'b01:   cred_q <= cred_q + rn_pkg::cred_t'(1);
            default: cred_q <= cred_q;
         endcase
      end
   end

   assign has_credit = (cred_q != '0);

   a_credit_bound: assert property (
      @(posedge clk) disable iff (!arst_n)
      cred_q <= rn_pkg::SCH_CREDITS
   );

endmodule

`default_nettype wire

//--- rn_free_list.sv
//******************************
// Physical register free list
// Circular buffer with speculative head,
// committed head and tail
//******************************
`timescale 1ns/1ps
`default_nettype none

module rn_free_list
(
   input  logic                                   clk,
   input  logic                                   arst_n,
   input  logic                                   fire,
   input  logic                                   rollback,
   input  rn_pkg::rn_dec_t [rn_pkg::ISSUE_W-1:0]  dec,
   input  rn_pkg::rn_cmt_t [rn_pkg::ISSUE_W-1:0]  cmt,
   output rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  alloc_prd,
   output logic                                   enough
);

   rn_pkg::preg_t   fifo_q [rn_pkg::N_FREE];
   rn_pkg::fl_ptr_t spec_head_q;
   rn_pkg::fl_ptr_t cmt_head_q;
   rn_pkg::fl_ptr_t tail_q;
   rn_pkg::fl_ptr_t pop_ptr  [rn_pkg::ISSUE_W];
   rn_pkg::fl_ptr_t push_ptr [rn_pkg::ISSUE_W];
   rn_pkg::fl_ptr_t n_need;
   rn_pkg::fl_ptr_t n_push;
   rn_pkg::fl_ptr_t avail;
   logic            [rn_pkg::ISSUE_W-1:0] push_en;

   // Each writing slot takes the next unused entry
   always_comb
   begin
      n_need = '0;
      for (int i = 0; i < rn_pkg::ISSUE_W; i++)
      begin
         pop_ptr[i] = spec_head_q + n_need;
         if (dec[i].lrd_we)
         begin
            n_need = n_need + rn_pkg::fl_ptr_t'(1);
         end
      end
   end

   // Returned registers pack in at the tail in commit order
   always_comb
   begin
      n_push = '0;
      for (int i = 0; i < rn_pkg::ISSUE_W; i++)
      begin
         push_en[i]  = cmt[i].fire & cmt[i].prd_we;
         push_ptr[i] = tail_q + n_push;
         if (push_en[i])
         begin
            n_push = n_push + rn_pkg::fl_ptr_t'(1);
         end
      end
   end

   for (genvar i = 0; i < rn_pkg::ISSUE_W; i++)
   begin : g_alloc
      assign alloc_prd[i] = fifo_q[pop_ptr[i][rn_pkg::FL_AW-1:0]];
   end

   assign avail  = tail_q - spec_head_q;
   assign enough = (avail >= n_need);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < rn_pkg::N_FREE; i++)
         begin
            fifo_q[i] <= rn_pkg::preg_t'(rn_pkg::N_PREG - rn_pkg::N_FREE + i);
         end
      end
      else
      begin
         for (int i = 0; i < rn_pkg::ISSUE_W; i++)
         begin
            if (push_en[i])
            begin
               fifo_q[push_ptr[i][rn_pkg::FL_AW-1:0]] <= cmt[i].pfree;
            end
         end
      end
   end

   // Starts full: tail one lap ahead of both heads
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         spec_head_q <= '0;
         cmt_head_q  <= '0;
         tail_q      <= rn_pkg::fl_ptr_t'(rn_pkg::N_FREE);
      end
      else
      begin
         tail_q     <= tail_q + n_push;
         cmt_head_q <= cmt_head_q + n_push;
         if (rollback)
         begin
            spec_head_q <= cmt_head_q;
         end
         else if (fire)
         begin
            spec_head_q <= spec_head_q + n_need;
         end
      end
   end

   // Commits never outrun allocation, so free entries stay within one lap
   a_tail_within_lap: assert property (
      @(posedge clk) disable iff (!arst_n)
      avail <= rn_pkg::N_FREE
   );

   // Group handshake at the top must honour enough
   a_pop_needs_enough: assert property (
      @(posedge clk) disable iff (!arst_n)
      (fire && (n_need != '0)) |-> enough
   );

endmodule

`default_nettype wire

//--- rn_rat.sv
//******************************
// Register alias tables
// Speculative and architectural maps, in-group
// RAW/WAW bypass and rollback restore
//******************************
`timescale 1ns/1ps
`default_nettype none

module rn_rat
(
   input  logic                                   clk,
   input  logic                                   arst_n,
   input  logic                                   fire,
   input  logic                                   rollback,
   input  rn_pkg::rn_dec_t [rn_pkg::ISSUE_W-1:0]  dec,
   input  rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  alloc_prd,
   input  rn_pkg::rn_cmt_t [rn_pkg::ISSUE_W-1:0]  cmt,
   output rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  prs1,
   output rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  prs2,
   output rn_pkg::preg_t   [rn_pkg::ISSUE_W-1:0]  pfree
);

   rn_pkg::preg_t spec_q [rn_pkg::N_LREG];
   rn_pkg::preg_t arch_q [rn_pkg::N_LREG];

   // Speculative map, written by each renamed group
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < rn_pkg::N_LREG; i++)
         begin
            spec_q[i] <= rn_pkg::preg_t'(i);
         end
      end
      else if (rollback)
      begin
         spec_q <= arch_q;
      end
      else if (fire)
      begin
         // Later slot lands last so it wins on a shared lrd
         for (int i = 0; i < rn_pkg::ISSUE_W; i++)
         begin
            if (dec[i].lrd_we)
            begin
               spec_q[dec[i].lrd] <= alloc_prd[i];
            end
         end
      end
   end

   // Architectural map follows the commit stream
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < rn_pkg::N_LREG; i++)
         begin
            arch_q[i] <= rn_pkg::preg_t'(i);
         end
      end
      else
      begin
         for (int i = 0; i < rn_pkg::ISSUE_W; i++)
         begin
            if (cmt[i].fire && cmt[i].prd_we)
            begin
               arch_q[cmt[i].lrd] <= cmt[i].prd;
            end
         end
      end
   end

   // Table lookup, then bypass from older slots of the same group
   always_comb
   begin
      for (int i = 0; i < rn_pkg::ISSUE_W; i++)
      begin
         prs1[i]  = spec_q[dec[i].lrs1];
         prs2[i]  = spec_q[dec[i].lrs2];
         pfree[i] = spec_q[dec[i].lrd];
         // Nearest older writer is checked last
         for (int k = 0; k < i; k++)
         begin
            if (dec[k].lrd_we && (dec[i].lrs1 == dec[k].lrd))
            begin
               prs1[i] = alloc_prd[k];
            end
            if (dec[k].lrd_we && (dec[i].lrs2 == dec[k].lrd))
            begin
               prs2[i] = alloc_prd[k];
            end
            // WAW: the older slot's new register is what this one displaces
            if (dec[k].lrd_we && dec[i].lrd_we && (dec[i].lrd == dec[k].lrd))
            begin
               pfree[i] = alloc_prd[k];
            end
         end
      end
   end

   // The front end is held off while a rollback restores the map
   a_no_fire_on_rollback: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(fire && rollback)
   );

endmodule

`default_nettype wire

//--- rn_decode.sv
//******************************
// Rename decode
// Pulls register fields and use flags out of
// the two instruction words of a group
//******************************
`timescale 1ns/1ps
`default_nettype none

module rn_decode
(
   input  rn_pkg::insn_t   [rn_pkg::ISSUE_W-1:0] grp_insn,
   input  logic            [rn_pkg::ISSUE_W-1:0] grp_valid,
   output rn_pkg::rn_dec_t [rn_pkg::ISSUE_W-1:0] dec
);

   for (genvar i = 0; i < rn_pkg::ISSUE_W; i++)
   begin : g_slot
      logic [6:0]    opc;
      rn_pkg::lreg_t rd;
      logic          use1;
      logic          use2;
      logic          wr;

      assign opc = grp_insn[i][6:0];
      assign rd  = grp_insn[i][11:7];

      // Source use and destination write by major opcode
      always_comb
      begin
         case (opc)
            rn_pkg::OPC_OP:     {use1, use2, wr} = 3'b111;
            rn_pkg::OPC_OP_IMM: {use1, use2, wr} = 3'b101;
            rn_pkg::OPC_LOAD:   {use1, use2, wr} = 3'b101;
            rn_pkg::OPC_STORE:  {use1, use2, wr} = 3'b110;
            rn_pkg::OPC_BRANCH: {use1, use2, wr} = 3'b110;
            rn_pkg::OPC_LUI:    {use1, use2, wr} = 3'b001;
            default:            {use1, use2, wr} = 3'b000;
         endcase
      end

      // x0 never gets a physical register
      assign dec[i] = '{
         lrs1:    grp_insn[i][19:15],
         lrs2:    grp_insn[i][24:20],
         lrd:     rd,
         rs1_use: grp_valid[i] & use1,
         rs2_use: grp_valid[i] & use2,
         lrd_we:  grp_valid[i] & wr & (rd != '0),
         valid:   grp_valid[i]
      };
   end

endmodule

`default_nettype wire

//--- rn_pkg.sv
//******************************
// Rename stage package
// Register widths, free-list and credit sizing,
// decoded, renamed and commit slot structs
//******************************
`default_nettype none

package rn_pkg;

   // Group and register file sizing
   localparam int ISSUE_W     = 2;
   localparam int LRF_AW      = 5;
   localparam int PRF_AW      = 6;
   localparam int N_LREG      = 32;
   localparam int N_PREG      = 64;
   localparam int N_FREE      = N_PREG - N_LREG;
   localparam int FL_AW       = 5;

   // Scheduler slots for renamed groups
   localparam int SCH_CREDITS = 4;
   localparam int CRED_W      = 3;

   // RV32 major opcodes that touch registers
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   typedef logic [31:0]       insn_t;
   typedef logic [LRF_AW-1:0] lreg_t;
   typedef logic [PRF_AW-1:0] preg_t;

   // Free-list pointer with one wrap bit
   typedef logic [FL_AW:0]    fl_ptr_t;
   typedef logic [CRED_W-1:0] cred_t;

   typedef struct packed {
      lreg_t lrs1;
      lreg_t lrs2;
      lreg_t lrd;
      logic  rs1_use;
      logic  rs2_use;
      logic  lrd_we;
      logic  valid;
   } rn_dec_t;

   typedef struct packed {
      preg_t prs1;
      preg_t prs2;
      preg_t prd;
      preg_t pfree;
      logic  rs1_use;
      logic  rs2_use;
      logic  lrd_we;
      logic  valid;
   } rn_out_t;

   // One retiring instruction as reported by the ROB
   typedef struct packed {
      logic  fire;
      logic  prd_we;
      lreg_t lrd;
      preg_t prd;
      preg_t pfree;
   } rn_cmt_t;

endpackage

`default_nettype wire
